/* project.f */
+incdir+rtl
rtl/tetris_pkg.sv
rtl/pixel_locator.sv
rtl/piece_geometry.sv
rtl/board_store.sv
rtl/game_ctrl.sv
rtl/pixel_shader.sv
rtl/tetris_top.sv
bench/tb_tetris.sv

/* Makefile */
# Verilator build and run of the tetris testbench

BIN := obj_dir/Vtb_tetris

.PHONY: all run clean

all: run

$(BIN): project.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_tetris -o Vtb_tetris

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf obj_dir

/* bench/tb_tetris.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_defines.svh"

module tb_tetris import tetris_pkg::*; ();

    localparam int FALL_TICKS = 3000;
    localparam int HOLD_TICKS = 8;
    localparam int READY_LIMIT = 200;
    localparam int FALL_LIMIT = 2 * FALL_TICKS + 100;

    localparam logic [7:0] LO  = 8'(`SHADE_LO);
    localparam logic [7:0] HI  = 8'(`SHADE_HI);
    localparam logic [7:0] MID = 8'(`SHADE_MID);

    // One table entry: action, then a pixel probe and its expected code
    typedef struct packed {
        logic [7:0] key;   // 0 means no key
        logic       fall;  // Wait for a gravity step
        logic [1:0] spot;  // 0 cell centre, 1 grid line, 2 outside
        logic [3:0] col;
        logic [4:0] row;
        logic [3:0] code;  // 8 is white
    } step_t;

    logic       i_clk = 1'b0;
    logic       i_rst_n;
    logic [9:0] i_x;
    logic [9:0] i_y;
    logic [7:0] i_key;
    logic [7:0] o_vga_r;
    logic [7:0] o_vga_g;
    logic [7:0] o_vga_b;
    logic       o_ready;

    step_t steps[$];
    int    checks = 0;
    int    errors = 0;
    int    timeouts = 0;

    tetris_top #(
        .P_FALL_TICKS(FALL_TICKS),
        .P_HOLD_TICKS(HOLD_TICKS)
    ) dut (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_x    (i_x),
        .i_y    (i_y),
        .i_key  (i_key),
        .o_vga_r(o_vga_r),
        .o_vga_g(o_vga_g),
        .o_vga_b(o_vga_b),
        .o_ready(o_ready)
    );

    always #2 i_clk = ~i_clk;

    function automatic rgb_t palette_rgb(input logic [3:0] code);
        case (code)
            4'd1:    return '{r: HI, g: LO, b: LO};
            4'd2:    return '{r: LO, g: HI, b: LO};
            4'd3:    return '{r: LO, g: LO, b: HI};
            4'd4:    return '{r: LO, g: HI, b: HI};
            4'd5:    return '{r: HI, g: LO, b: HI};
            4'd6:    return '{r: HI, g: HI, b: LO};
            4'd7:    return '{r: HI, g: MID, b: 8'd0};
            4'd8:    return '{r: HI, g: HI, b: HI}; // Grid line
            default: return '{r: LO, g: LO, b: LO};
        endcase
    endfunction

    task automatic add_step(input logic [7:0] key, input logic fall, input logic [1:0] spot,
                            input int col, input int row, input int code);
        step_t s;
        s = '{key: key, fall: fall, spot: spot, col: 4'(col), row: 5'(row), code: 4'(code)};
        steps.push_back(s);
    endtask

    task automatic check_value(input logic [23:0] got, input logic [23:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Polls o_ready on falling edges
    task automatic wait_ready(input logic level, input int limit, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < limit) begin
            @(negedge i_clk);
            if (o_ready === level) begin
                ok = 1'b1;
            end
            n++;
        end
        if (!ok) begin
            timeouts++;
            $display("Timed out at %0t waiting for o_ready to become %0d", $time, level);
        end
    endtask

    task automatic run_step(input int idx, input step_t s);
        bit         ok;
        logic [9:0] px;
        logic [9:0] py;
        rgb_t       got;
        wait_ready(1'b1, READY_LIMIT, ok);
        if (ok && (s.key != 8'h00 || s.fall)) begin
            i_key = s.key;
            wait_ready(1'b0, s.fall ? FALL_LIMIT : READY_LIMIT, ok);
            i_key = 8'h00;
            if (ok) begin
                wait_ready(1'b1, READY_LIMIT, ok);
            end
        end
        if (ok) begin
            case (s.spot)
                2'd1:    px = 10'(`FIELD_X0 + `CELL_PX * int'(s.col));
                2'd2:    px = 10'd100;
                default: px = 10'(`FIELD_X0 + `CELL_PX * int'(s.col) + `CELL_PX / 2);
            endcase
            py = (s.spot == 2'd2) ? 10'd100
                                  : 10'(`FIELD_Y0 + `CELL_PX * int'(s.row) + `CELL_PX / 2);
            i_x = px;
            i_y = py;
            #1; // Mid low phase, pixel path settled
            got = '{r: o_vga_r, g: o_vga_g, b: o_vga_b};
            check_value(got, palette_rgb(s.code),
                        $sformatf("step %0d cell (%0d,%0d)", idx, s.col, s.row));
        end
    endtask

    task automatic build_table();
        add_step(8'h00, 1'b0, 2'd2, 0, 0, 0);
        add_step(8'h00, 1'b0, 2'd1, 3, 10, 8);
        add_step(8'h00, 1'b0, 2'd0, 0, 10, 0);
        // First piece, shape 0 at the spawn cell
        add_step(8'h00, 1'b0, 2'd0, 3, 1, 1);
        add_step(8'h00, 1'b0, 2'd0, 4, 1, 1);
        add_step(8'h00, 1'b0, 2'd0, 4, 2, 1);
        add_step(8'h00, 1'b0, 2'd0, 5, 2, 1);
        add_step(8'h00, 1'b0, 2'd0, 6, 2, 0);
        add_step(`KEY_RIGHT, 1'b0, 2'd0, 6, 2, 1);
        add_step(8'h00, 1'b0, 2'd0, 3, 1, 0);
        // Walk to the left wall
        add_step(`KEY_LEFT, 1'b0, 2'd0, 3, 1, 1);
        add_step(`KEY_LEFT, 1'b0, 2'd0, 2, 1, 1);
        add_step(`KEY_LEFT, 1'b0, 2'd0, 1, 1, 1);
        add_step(`KEY_LEFT, 1'b0, 2'd0, 0, 1, 1);
        add_step(`KEY_LEFT, 1'b0, 2'd0, 2, 2, 1); // Blocked by wall
        add_step(8'h00, 1'b0, 2'd0, 3, 2, 0);
        add_step(`KEY_LEFT, 1'b0, 2'd0, 0, 1, 1);
        add_step(8'h00, 1'b0, 2'd0, 2, 2, 1);
        // Hard drop onto the floor
        add_step(`KEY_DOWN, 1'b0, 2'd0, 0, 18, 1);
        add_step(8'h00, 1'b0, 2'd0, 1, 19, 1);
        add_step(8'h00, 1'b0, 2'd0, 2, 19, 1);
        add_step(8'h00, 1'b0, 2'd0, 3, 19, 0);
        add_step(8'h00, 1'b0, 2'd0, 1, 2, 0);
        add_step(8'h00, 1'b0, 2'd0, 3, 1, 2);
        add_step(8'h00, 1'b0, 2'd0, 5, 0, 2);
        // Shape 1 turned to direction 1
        add_step(`KEY_UP, 1'b0, 2'd0, 5, 1, 2);
        add_step(8'h00, 1'b0, 2'd0, 5, 2, 2);
        add_step(8'h00, 1'b0, 2'd0, 4, 0, 2);
        add_step(8'h00, 1'b0, 2'd0, 3, 1, 0);
        // Gravity moves it one row
        add_step(8'h00, 1'b1, 2'd0, 5, 3, 2);
        add_step(8'h00, 1'b0, 2'd0, 4, 1, 2);
        add_step(8'h00, 1'b0, 2'd0, 4, 0, 0);
        add_step(8'h00, 1'b0, 2'd0, 1, 18, 1);
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_x = '0;
        i_y = '0;
        i_key = 8'h00;
        build_table();
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        check_value(24'(o_ready), 24'd0, "o_ready after reset");
        // Hold-off after reset is exactly HOLD_TICKS cycles
        repeat (HOLD_TICKS - 1) @(negedge i_clk);
        check_value(24'(o_ready), 24'd0, "o_ready before hold-off ends");
        @(negedge i_clk);
        check_value(24'(o_ready), 24'd1, "o_ready after hold-off");
        for (int i = 0; i < steps.size() && timeouts == 0; i++) begin
            run_step(i, steps[i]);
        end
        $display("Summary: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/tetris_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_top import tetris_pkg::*; #(
    parameter int unsigned P_FALL_TICKS = 2**25,
    parameter int unsigned P_HOLD_TICKS = 2**23
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic [9:0] i_x,
    input  wire logic [9:0] i_y,
    input  wire logic [7:0] i_key,
    output logic [7:0]      o_vga_r,
    output logic [7:0]      o_vga_g,
    output logic [7:0]      o_vga_b,
    output logic            o_ready
);

    pixel_loc_t   loc;
    piece_pose_t  pose;
    piece_pose_t  cand;
    piece_cells_t cur_cells;
    piece_cells_t cand_cells;
    logic         fits;
    logic         lock;
    colour_code_t lock_colour;
    colour_code_t pix_code;
    rgb_t         rgb;

    pixel_locator u_locator (.i_x(i_x), .i_y(i_y), .o_loc(loc));

    game_ctrl #(
        .P_FALL_TICKS(P_FALL_TICKS),
        .P_HOLD_TICKS(P_HOLD_TICKS)
    ) u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_key        (i_key),
        .i_fits       (fits),
        .o_pose       (pose),
        .o_cand       (cand),
        .o_lock       (lock),
        .o_lock_colour(lock_colour),
        .o_ready      (o_ready)
    );

    piece_geometry geo_cur (.i_pose(pose), .o_cells(cur_cells));
    piece_geometry geo_cand (.i_pose(cand), .o_cells(cand_cells));

    board_store u_board (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_loc        (loc),
        .i_probe      (cand_cells),
        .i_lock       (lock),
        .i_lock_cells (cur_cells),
        .i_lock_colour(lock_colour),
        .o_fits       (fits),
        .o_pix_code   (pix_code)
    );

    pixel_shader u_shader (
        .i_loc       (loc),
        .i_piece     (cur_cells),
        .i_shape     (pose.shape),
        .i_board_code(pix_code),
        .o_rgb       (rgb)
    );

    assign o_vga_r = rgb.r;
    assign o_vga_g = rgb.g;
    assign o_vga_b = rgb.b;

endmodule

`default_nettype wire

/* rtl/pixel_shader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_defines.svh"

module pixel_shader import tetris_pkg::*; (
    input  wire pixel_loc_t   i_loc,
    input  wire piece_cells_t i_piece,
    input  wire shape_t       i_shape,
    input  wire colour_code_t i_board_code,
    output rgb_t              o_rgb
);

    localparam logic [7:0] LO  = 8'(`SHADE_LO);
    localparam logic [7:0] HI  = 8'(`SHADE_HI);
    localparam logic [7:0] MID = 8'(`SHADE_MID);

    logic in_piece;

    function automatic rgb_t palette(input colour_code_t code);
        case (code)
            3'd1:    return '{r: HI, g: LO, b: LO};
            3'd2:    return '{r: LO, g: HI, b: LO};
            3'd3:    return '{r: LO, g: LO, b: HI};
            3'd4:    return '{r: LO, g: HI, b: HI};
            3'd5:    return '{r: HI, g: LO, b: HI};
            3'd6:    return '{r: HI, g: HI, b: LO};
            3'd7:    return '{r: HI, g: MID, b: 8'd0}; // Orange
            default: return '{r: LO, g: LO, b: LO};
        endcase
    endfunction

    always_comb begin
        in_piece = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if ((i_piece[k].col == $signed({2'b00, i_loc.col})) &&
                (i_piece[k].row == $signed({1'b0, i_loc.row}))) begin
                in_piece = 1'b1;
            end
        end
    end

    always_comb begin
        if (!i_loc.in_field) begin
            o_rgb = '{r: LO, g: LO, b: LO};
        end else if (i_loc.on_line) begin
            o_rgb = '{r: HI, g: HI, b: HI};
        end else if (in_piece) begin
            o_rgb = palette(colour_code_t'(i_shape + 3'd1));
        end else begin
            o_rgb = palette(i_board_code);
        end
    end

endmodule

`default_nettype wire

/* rtl/game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_defines.svh"

module game_ctrl import tetris_pkg::*; #(
    parameter int unsigned P_FALL_TICKS = 2**25,
    parameter int unsigned P_HOLD_TICKS = 2**23
) (
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    input  wire logic [7:0] i_key,
    input  wire logic  i_fits,
    output piece_pose_t o_pose,
    output piece_pose_t o_cand,
    output logic        o_lock,
    output colour_code_t o_lock_colour,
    output logic        o_ready
);

    localparam int unsigned FALL_W = $clog2(P_FALL_TICKS);
    localparam int unsigned HOLD_W = $clog2(P_HOLD_TICKS + 1);

    ctrl_state_t       state;
    move_t             kind;
    piece_pose_t       pose;
    piece_pose_t       cand;
    logic [FALL_W-1:0] fall_cnt;
    logic              fall_wrap;
    logic [HOLD_W-1:0] hold_cnt;
    shape_t            next_shape;

    function automatic piece_pose_t spawn(input shape_t s);
        piece_pose_t p;
        p.shape = s;
        p.dir = 2'd0;
        p.centre.col = 6'(`SPAWN_COL);
        p.centre.row = 6'(`SPAWN_ROW);
        return p;
    endfunction

    assign fall_wrap = (fall_cnt == FALL_W'(P_FALL_TICKS - 1));
    assign next_shape = (pose.shape == 3'd6) ? 3'd0 : pose.shape + 3'd1;

    // Gravity timer runs regardless of state
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fall_cnt <= '0;
        end else begin
            fall_cnt <= fall_wrap ? '0 : fall_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= HOLD;
            kind <= MV_SHIFT;
            hold_cnt <= '0;
            pose <= spawn(3'd0);
            cand <= spawn(3'd0);
        end else begin
            case (state)
                IDLE: begin
                    hold_cnt <= '0;
                    state <= CHECK;
                    kind <= MV_SHIFT;
                    cand <= pose;
                    case (i_key)
                        `KEY_LEFT:  cand.centre.col <= pose.centre.col - 6'sd1;
                        `KEY_RIGHT: cand.centre.col <= pose.centre.col + 6'sd1;
                        `KEY_UP:    cand.dir <= pose.dir + 2'd1;
                        `KEY_DOWN: begin
                            cand.centre.row <= pose.centre.row + 6'sd1;
                            kind <= MV_DROP;
                        end
                        default: begin // Gravity step, only on a wrap
                            cand.centre.row <= pose.centre.row + 6'sd1;
                            kind <= MV_FALL;
                            if (!fall_wrap) begin
                                state <= IDLE;
                            end
                        end
                    endcase
                end
                CHECK: begin
                    hold_cnt <= '0;
                    if (i_fits) begin
                        pose <= cand;
                        if (kind == MV_DROP) begin
                            cand.centre.row <= cand.centre.row + 6'sd1; // Keep falling
                        end else begin
                            state <= HOLD;
                        end
                    end else if (kind == MV_SHIFT) begin
                        state <= HOLD; // Blocked move is dropped
                    end else begin
                        state <= LOCK;
                    end
                end
                LOCK: begin
                    hold_cnt <= '0;
                    pose <= spawn(next_shape);
                    state <= HOLD;
                end
                default: begin
                    hold_cnt <= hold_cnt + 1'b1;
                    if (hold_cnt == HOLD_W'(P_HOLD_TICKS - 1)) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    assign o_pose = pose;
    assign o_cand = cand;
    assign o_lock = (state == LOCK);
    assign o_lock_colour = colour_code_t'(pose.shape + 3'd1);
    assign o_ready = (state == IDLE);

    assert property (@(posedge i_clk) disable iff (!i_rst_n) o_lock |=> !o_lock)
        else $error("game_ctrl: lock pulse longer than one cycle");

endmodule

`default_nettype wire

/* rtl/board_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_defines.svh"

module board_store import tetris_pkg::*; (
    input  wire logic         i_clk,
    input  wire logic         i_rst_n,
    input  wire pixel_loc_t   i_loc,
    input  wire piece_cells_t i_probe,
    input  wire logic         i_lock,
    input  wire piece_cells_t i_lock_cells,
    input  wire colour_code_t i_lock_colour,
    output logic              o_fits,
    output colour_code_t      o_pix_code
);

    colour_code_t grid [`BOARD_ROWS][`BOARD_COLS];

    function automatic logic in_board(input cell_xy_t c);
        return (c.col >= 0) && (c.col < `BOARD_COLS) && (c.row >= 0) && (c.row < `BOARD_ROWS);
    endfunction

    function automatic logic all_in_board(input piece_cells_t p);
        return in_board(p[0]) && in_board(p[1]) && in_board(p[2]) && in_board(p[3]);
    endfunction

    always_comb begin
        o_fits = 1'b1;
        for (int k = 0; k < 4; k++) begin
            if (!in_board(i_probe[k])) begin
                o_fits = 1'b0;
            end else if (grid[i_probe[k].row[4:0]][i_probe[k].col[3:0]] != 3'd0) begin
                o_fits = 1'b0; // Occupied
            end
        end
    end

    assign o_pix_code = grid[i_loc.row][i_loc.col];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < `BOARD_ROWS; r++) begin
                for (int c = 0; c < `BOARD_COLS; c++) begin
                    grid[r][c] <= 3'd0;
                end
            end
        end else if (i_lock) begin
            for (int k = 0; k < 4; k++) begin
                grid[i_lock_cells[k].row[4:0]][i_lock_cells[k].col[3:0]] <= i_lock_colour;
            end
        end
    end

    // Controller only locks a pose that already passed the fit check
    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_lock |-> all_in_board(i_lock_cells))
        else $error("board_store: lock cells outside board");

endmodule

`default_nettype wire

/* rtl/piece_geometry.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_geometry import tetris_pkg::*; (
    input  wire piece_pose_t i_pose,
    output piece_cells_t     o_cells
);

    typedef struct packed {
        logic signed [2:0] dx;
        logic signed [2:0] dy;
    } off_t;

    typedef off_t [2:0] off3_t;

    off3_t offs;

    function automatic off3_t mk(input int dx1, input int dy1, input int dx2,
                                 input int dy2, input int dx3, input int dy3);
        off3_t t;
        t[0] = '{dx: 3'(dx1), dy: 3'(dy1)};
        t[1] = '{dx: 3'(dx2), dy: 3'(dy2)};
        t[2] = '{dx: 3'(dx3), dy: 3'(dy3)};
        return t;
    endfunction

    // Offsets of the three cells around the centre, as (col, row)
    always_comb begin
        case (i_pose.shape)
            3'd0: begin // S-like, two poses
                if (!i_pose.dir[0])
                    offs = mk(-1, 0, 0, 1, 1, 1);
                else
                    offs = mk(0, -1, -1, 0, -1, 1);
            end
            3'd1: begin
                if (!i_pose.dir[0])
                    offs = mk(-1, 0, 0, -1, 1, -1);
                else
                    offs = mk(0, -1, 1, 0, 1, 1);
            end
            3'd2: begin // T
                case (i_pose.dir)
                    2'd0:    offs = mk(-1, 0, 0, 1, 1, 0);
                    2'd1:    offs = mk(-1, 0, 0, -1, 0, 1);
                    2'd2:    offs = mk(-1, 0, 0, -1, 1, 0);
                    default: offs = mk(0, -1, 1, 0, 0, 1);
                endcase
            end
            3'd3: begin // Bar
                if (!i_pose.dir[0])
                    offs = mk(-1, 0, 1, 0, 2, 0);
                else
                    offs = mk(0, -1, 0, 1, 0, 2);
            end
            3'd4: begin
                case (i_pose.dir)
                    2'd0:    offs = mk(-1, 0, 1, 0, 1, 1);
                    2'd1:    offs = mk(-1, 1, 0, -1, 0, 1);
                    2'd2:    offs = mk(0, -1, 0, 1, 1, -1);
                    default: offs = mk(-1, -1, -1, 0, 1, 0);
                endcase
            end
            3'd5: begin
                case (i_pose.dir)
                    2'd0:    offs = mk(-1, -1, 0, -1, 0, 1);
                    2'd1:    offs = mk(-1, 0, 1, 0, 1, -1);
                    2'd2:    offs = mk(-1, 0, -1, 1, 1, 0);
                    default: offs = mk(0, -1, 0, 1, 1, 1);
                endcase
            end
            3'd6: offs = mk(0, 1, 1, 0, 1, 1); // Square, no rotation
            default: offs = mk(-1, 0, 0, 1, 1, 1);
        endcase
    end

    always_comb begin
        o_cells[0] = i_pose.centre;
        for (int k = 1; k < 4; k++) begin
            o_cells[k].col = i_pose.centre.col + {{3{offs[k-1].dx[2]}}, offs[k-1].dx};
            o_cells[k].row = i_pose.centre.row + {{3{offs[k-1].dy[2]}}, offs[k-1].dy};
        end
    end

endmodule

`default_nettype wire

/* rtl/pixel_locator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_defines.svh"

module pixel_locator import tetris_pkg::*; (
    input  wire logic [9:0] i_x,
    input  wire logic [9:0] i_y,
    output pixel_loc_t      o_loc
);

    logic [9:0] dx;
    logic [9:0] dy;
    logic [9:0] col_q;
    logic [9:0] row_q;

    assign dx = i_x - 10'(`FIELD_X0);
    assign dy = i_y - 10'(`FIELD_Y0);
    assign col_q = dx / 10'(`CELL_PX);
    assign row_q = dy / 10'(`CELL_PX);

    always_comb begin
        o_loc.in_field = (i_x >= 10'(`FIELD_X0)) && (i_x <= 10'(`FIELD_X1)) &&
                         (i_y >= 10'(`FIELD_Y0)) && (i_y <= 10'(`FIELD_Y1));
        o_loc.on_line = (dx % 10'(`CELL_PX) == 10'd0) || (dy % 10'(`CELL_PX) == 10'd0);
        // Far edge lines fold into the last cell so board reads stay in range
        o_loc.col = (col_q < 10'(`BOARD_COLS)) ? col_q[3:0] : 4'(`BOARD_COLS - 1);
        o_loc.row = (row_q < 10'(`BOARD_ROWS)) ? row_q[4:0] : 5'(`BOARD_ROWS - 1);
        // Field edges must agree with board size times pitch
        if (o_loc.in_field && !o_loc.on_line) begin
            assert ((col_q < 10'(`BOARD_COLS)) && (row_q < 10'(`BOARD_ROWS)))
                else $error("pixel_locator: field pixel maps outside board");
        end
    end

endmodule

`default_nettype wire

/* rtl/tetris_pkg.sv */
`default_nettype none

package tetris_pkg;

    typedef logic [2:0] colour_code_t; // 0 empty, 1..7 colours
    typedef logic [2:0] shape_t;
    typedef logic [1:0] dir_t;

    // Signed so that cells off the board stay visible
    typedef struct packed {
        logic signed [5:0] col;
        logic signed [5:0] row;
    } cell_xy_t;

    typedef struct packed {
        shape_t   shape;
        dir_t     dir;
        cell_xy_t centre;
    } piece_pose_t;

    typedef cell_xy_t [3:0] piece_cells_t; // Element 0 is the centre

    typedef struct packed {
        logic       in_field;
        logic       on_line;
        logic [3:0] col;
        logic [4:0] row;
    } pixel_loc_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef enum logic [1:0] {IDLE, CHECK, LOCK, HOLD} ctrl_state_t;

    typedef enum logic [1:0] {MV_SHIFT, MV_FALL, MV_DROP} move_t;

endpackage

`default_nettype wire

/* rtl/tetris_defines.svh */
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// Board size in cells
`define BOARD_COLS 10
`define BOARD_ROWS 20

`define CELL_PX 20

// Field edges, inclusive
`define FIELD_X0 220
`define FIELD_Y0 40
`define FIELD_X1 420
`define FIELD_Y1 440

// Keyboard scancodes
`define KEY_UP    8'h75
`define KEY_DOWN  8'h72
`define KEY_RIGHT 8'h74
`define KEY_LEFT  8'h6b

`define SPAWN_COL 4
`define SPAWN_ROW 1

`define SHADE_LO  20
`define SHADE_HI  255
`define SHADE_MID 100

`endif
